// File: hw/rx_pkg.sv
//********************************************************************
// Serial receive path shared definitions
// Word, tap and bus types, control states, register map, training
//********************************************************************
package rx_pkg;

    localparam int WORD_W      = 10;  // Bits per deserialized word
    localparam int TAP_W       = 5;   // Delay tap select width
    localparam int FIFO_DEPTH  = 16;  // Capture FIFO entries
    localparam int LOCK_CYCLES = 255; // Reset release to lock

    typedef logic [WORD_W-1:0] rx_word_t;
    typedef logic [TAP_W-1:0]  rx_tap_t;
    typedef logic [4:0]        fifo_count_t; // Level 0 to 16
    typedef logic [3:0]        slip_count_t;
    typedef logic [3:0]        axi_addr_t;   // Byte address
    typedef logic [31:0]       axi_data_t;

    typedef enum logic [2:0] {
        ST_WAIT_LOCK, // Lock timer running
        ST_IDLE,      // Locked, waiting for start
        ST_TRAIN,     // Bitslip until training word repeats
        ST_RUN,       // Aligned, words go to FIFO
        ST_FAIL       // Out of slips
    } rx_state_t;

    // Training
    localparam rx_word_t TRAIN_WORD    = 10'h3E0; // Ten distinct rotations
    localparam int       TRAIN_MATCHES = 2;
    localparam int       MAX_SLIPS     = 10;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    //****************************************************************
    // Register map
    //****************************************************************
    localparam axi_addr_t ADDR_CTRL   = 4'h0; // Enable, start, tap
    localparam axi_addr_t ADDR_STATUS = 4'h4; // Flags and FIFO level
    localparam axi_addr_t ADDR_DATA   = 4'h8; // Read pops one word
    localparam axi_addr_t ADDR_SLIPS  = 4'hC; // Slips of last training

endpackage

// File: hw/rx_bit_delay.sv
//********************************************************************
// Serial tap delay line
// Output stage selected by the CTRL tap field
//********************************************************************
`timescale 1ns/1ps

module rx_bit_delay (
    input  logic           clkGHz_clkbuf,
    input  logic           reset_buf_n,
    input  logic           serial_in,
    input  rx_pkg::rx_tap_t tap,
    output logic           delayed_bit
);

    logic [(1 << rx_pkg::TAP_W)-1:0] stage_q; // One stage per tap value

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[(1 << rx_pkg::TAP_W)-2:0], serial_in}; // Sample every clock
        end
    end

    assign delayed_bit = stage_q[tap]; // Tap 0 gives one cycle

endmodule

// File: hw/rx_deserializer.sv
//********************************************************************
// 10-bit deserializer with bitslip
// MSB first, one word strobe per completed word
//********************************************************************
`timescale 1ns/1ps

module rx_deserializer (
    input  logic            clkGHz_clkbuf,
    input  logic            reset_buf_n,
    input  logic            delayed_bit,
    input  logic            rx_enable,
    input  logic            bitslip,
    output rx_pkg::rx_word_t word,
    output logic            word_valid
);

    rx_pkg::rx_word_t shift_q; // Word being assembled
    logic [3:0]       bit_cnt; // Bits counted in current word
    logic             last_bit;

    assign last_bit = (bit_cnt == 4'(rx_pkg::WORD_W - 1)) && !bitslip;

    // Bit counter and strobe
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!rx_enable) begin
                bit_cnt <= '0; // Restart on disable
            end else if (last_bit) begin
                bit_cnt    <= '0;
                word_valid <= 1'b1;
            end else if (!bitslip) begin
                bit_cnt <= bit_cnt + 4'd1; // Held during a slip
            end
        end
    end

    // Datapath
    always_ff @(posedge clkGHz_clkbuf) begin
        if (rx_enable) begin
            shift_q <= {shift_q[rx_pkg::WORD_W-2:0], delayed_bit};
            if (last_bit) begin
                word <= {shift_q[rx_pkg::WORD_W-2:0], delayed_bit}; // First bit at MSB
            end
        end
    end

endmodule

// File: hw/rx_word_fifo.sv
//********************************************************************
// Capture FIFO for received words
// 16 entries, level count, sticky overflow on dropped pushes
//********************************************************************
`timescale 1ns/1ps

module rx_word_fifo (
    input  logic               clkGHz_clkbuf,
    input  logic               reset_buf_n,
    input  rx_pkg::rx_word_t   word,
    input  logic               word_valid,
    input  logic               push_enable,
    input  logic               pop,
    input  logic               clear_overflow,
    output rx_pkg::rx_word_t   head_word,
    output logic               empty,
    output rx_pkg::fifo_count_t level,
    output logic               overflow
);

    rx_pkg::rx_word_t mem [rx_pkg::FIFO_DEPTH];
    logic [$clog2(rx_pkg::FIFO_DEPTH)-1:0] wr_ptr, rd_ptr; // Wrap naturally
    logic push_req, full, do_push, do_pop;

    assign push_req = word_valid && push_enable;
    assign full     = (level == rx_pkg::fifo_count_t'(rx_pkg::FIFO_DEPTH));
    assign empty    = (level == '0);
    assign do_push  = push_req && !full;
    assign do_pop   = pop && !empty;
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level; // Both or neither
            endcase
            if (push_req && full) begin
                overflow <= 1'b1; // Loss wins over clear
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (do_push) mem[wr_ptr] <= word;
    end

endmodule

// File: hw/rx_ctrl.sv
//********************************************************************
// Receive control with AXI4-Lite register slave
// Lock timer, word alignment training, FIFO push and pop
//********************************************************************
`timescale 1ns/1ps

module rx_ctrl (
    input  logic                clkGHz_clkbuf,
    input  logic                reset_buf_n,
    input  rx_pkg::axi_addr_t   s_axi_awaddr,
    input  logic                s_axi_awvalid,
    output logic                s_axi_awready,
    input  rx_pkg::axi_data_t   s_axi_wdata,
    input  logic [3:0]          s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,
    output logic [1:0]          s_axi_bresp,
    output logic                s_axi_bvalid,
    input  logic                s_axi_bready,
    input  rx_pkg::axi_addr_t   s_axi_araddr,
    input  logic                s_axi_arvalid,
    output logic                s_axi_arready,
    output rx_pkg::axi_data_t   s_axi_rdata,
    output logic [1:0]          s_axi_rresp,
    output logic                s_axi_rvalid,
    input  logic                s_axi_rready,
    input  rx_pkg::rx_word_t    word,
    input  logic                word_valid,
    input  rx_pkg::rx_word_t    head_word,
    input  logic                empty,
    input  rx_pkg::fifo_count_t level,
    input  logic                overflow,
    output rx_pkg::rx_tap_t     tap,
    output logic                rx_enable,
    output logic                bitslip,
    output logic                push_enable,
    output logic                pop,
    output logic                clear_overflow
);

    rx_pkg::rx_state_t   state;
    rx_pkg::slip_count_t slip_cnt;
    logic [7:0]          lock_cnt;
    logic [1:0]          match_cnt;  // Consecutive training matches
    logic                skip_word;  // Next word is partial after a slip
    logic                locked, enable_q, start_train, wr_fire, rd_fire;
    rx_pkg::axi_data_t   wmask, ctrl_now, ctrl_new, status_now;

    function automatic logic is_mapped(input rx_pkg::axi_addr_t addr);
        return addr == rx_pkg::ADDR_CTRL || addr == rx_pkg::ADDR_STATUS ||
               addr == rx_pkg::ADDR_DATA || addr == rx_pkg::ADDR_SLIPS;
    endfunction

    assign locked      = (lock_cnt == 8'(rx_pkg::LOCK_CYCLES));
    assign rx_enable   = enable_q && locked;
    assign push_enable = (state == rx_pkg::ST_RUN);
    assign wr_fire     = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign rd_fire     = s_axi_arready && s_axi_arvalid;

    // Byte lanes merged into CTRL
    assign wmask    = {{8{s_axi_wstrb[3]}}, {8{s_axi_wstrb[2]}},
                       {8{s_axi_wstrb[1]}}, {8{s_axi_wstrb[0]}}};
    assign ctrl_now = {23'd0, tap, 3'd0, enable_q}; // Start reads as 0
    assign ctrl_new = (ctrl_now & ~wmask) | (s_axi_wdata & wmask);
    assign status_now = {19'd0, level, 3'd0, overflow, empty,
                         state == rx_pkg::ST_FAIL, state == rx_pkg::ST_RUN, locked};

    //****************************************************************
    // Write channel and CTRL register
    //****************************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            s_axi_awready  <= 1'b0;
            s_axi_wready   <= 1'b0;
            s_axi_bvalid   <= 1'b0;
            s_axi_bresp    <= rx_pkg::AXI_RESP_OKAY;
            enable_q       <= 1'b0;
            tap            <= '0;
            start_train    <= 1'b0;
            clear_overflow <= 1'b0;
        end else begin
            start_train    <= 1'b0; // Self-clearing pulses
            clear_overflow <= 1'b0;
            s_axi_awready  <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
            s_axi_wready   <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
            if (s_axi_bvalid && s_axi_bready) s_axi_bvalid <= 1'b0;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                s_axi_bresp  <= is_mapped(s_axi_awaddr) ? rx_pkg::AXI_RESP_OKAY
                                                         : rx_pkg::AXI_RESP_SLVERR;
                if (s_axi_awaddr == rx_pkg::ADDR_CTRL) begin
                    enable_q    <= ctrl_new[0];
                    start_train <= ctrl_new[1];
                    tap         <= ctrl_new[8:4];
                end
                if (s_axi_awaddr == rx_pkg::ADDR_STATUS) begin
                    clear_overflow <= s_axi_wdata[4] && s_axi_wstrb[0]; // Write 1 to clear
                end
            end
        end
    end

    //****************************************************************
    // Read channel with a popping DATA read
    //****************************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rdata   <= '0;
            s_axi_rresp   <= rx_pkg::AXI_RESP_OKAY;
            pop           <= 1'b0;
        end else begin
            pop           <= 1'b0;
            s_axi_arready <= s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;
            if (s_axi_rvalid && s_axi_rready) s_axi_rvalid <= 1'b0;
            if (rd_fire) begin
                s_axi_rvalid <= 1'b1; // rdata held until rready
                s_axi_rresp  <= rx_pkg::AXI_RESP_OKAY;
                case (s_axi_araddr)
                    rx_pkg::ADDR_CTRL:   s_axi_rdata <= ctrl_now;
                    rx_pkg::ADDR_STATUS: s_axi_rdata <= status_now;
                    rx_pkg::ADDR_DATA: begin
                        s_axi_rdata <= empty ? '0 : {22'd0, head_word}; // Empty reads 0
                        pop         <= !empty;
                    end
                    rx_pkg::ADDR_SLIPS:  s_axi_rdata <= {28'd0, slip_cnt};
                    default: begin
                        s_axi_rdata <= '0;
                        s_axi_rresp <= rx_pkg::AXI_RESP_SLVERR;
                    end
                endcase
            end
        end
    end

    //****************************************************************
    // Lock timer and training FSM
    //****************************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            lock_cnt  <= '0;
            state     <= rx_pkg::ST_WAIT_LOCK;
            slip_cnt  <= '0;
            match_cnt <= '0;
            skip_word <= 1'b0;
            bitslip   <= 1'b0;
        end else begin
            bitslip <= 1'b0;
            if (!locked) lock_cnt <= lock_cnt + 8'd1;
            case (state)
                rx_pkg::ST_WAIT_LOCK: if (locked) state <= rx_pkg::ST_IDLE;
                rx_pkg::ST_TRAIN: if (word_valid) begin
                    if (skip_word) begin
                        skip_word <= 1'b0; // Drop partial word
                    end else if (word == rx_pkg::TRAIN_WORD) begin
                        if (match_cnt == 2'(rx_pkg::TRAIN_MATCHES - 1)) state <= rx_pkg::ST_RUN;
                        else match_cnt <= match_cnt + 2'd1;
                    end else if (slip_cnt == rx_pkg::slip_count_t'(rx_pkg::MAX_SLIPS)) begin
                        state <= rx_pkg::ST_FAIL; // Out of slips
                    end else begin
                        bitslip   <= 1'b1;
                        slip_cnt  <= slip_cnt + 1'b1;
                        skip_word <= 1'b1;
                        match_cnt <= '0;
                    end
                end
                default: ; // Idle, run and fail wait for start
            endcase
            if (start_train && state != rx_pkg::ST_WAIT_LOCK) begin
                state     <= rx_pkg::ST_TRAIN; // Retrain from any locked state
                slip_cnt  <= '0;
                match_cnt <= '0;
                skip_word <= 1'b0;
            end
        end
    end

endmodule

// File: hw/rx_top.sv
//********************************************************************
// Serial receive path top level
// Tap delay, deserializer, capture FIFO and AXI4-Lite control
//********************************************************************
`timescale 1ns/1ps

module rx_top (
    input  logic              clkGHz_clkbuf,
    input  logic              reset_buf_n,
    input  logic              serial_in,
    input  rx_pkg::axi_addr_t s_axi_awaddr,
    input  logic              s_axi_awvalid,
    output logic              s_axi_awready,
    input  rx_pkg::axi_data_t s_axi_wdata,
    input  logic [3:0]        s_axi_wstrb,
    input  logic              s_axi_wvalid,
    output logic              s_axi_wready,
    output logic [1:0]        s_axi_bresp,
    output logic              s_axi_bvalid,
    input  logic              s_axi_bready,
    input  rx_pkg::axi_addr_t s_axi_araddr,
    input  logic              s_axi_arvalid,
    output logic              s_axi_arready,
    output rx_pkg::axi_data_t s_axi_rdata,
    output logic [1:0]        s_axi_rresp,
    output logic              s_axi_rvalid,
    input  logic              s_axi_rready
);

    rx_pkg::rx_tap_t     tap;
    rx_pkg::rx_word_t    word, head_word;
    rx_pkg::fifo_count_t level;
    logic delayed_bit, rx_enable, bitslip, word_valid;
    logic push_enable, pop, clear_overflow, empty, overflow;

    rx_bit_delay u_delay (
        .clkGHz_clkbuf (clkGHz_clkbuf), .reset_buf_n (reset_buf_n),
        .serial_in     (serial_in),     .tap         (tap),
        .delayed_bit   (delayed_bit)
    );

    rx_deserializer u_deser (
        .clkGHz_clkbuf (clkGHz_clkbuf), .reset_buf_n (reset_buf_n),
        .delayed_bit   (delayed_bit),   .rx_enable   (rx_enable),
        .bitslip       (bitslip),       .word        (word),
        .word_valid    (word_valid)
    );

    rx_word_fifo u_fifo (
        .clkGHz_clkbuf (clkGHz_clkbuf), .reset_buf_n    (reset_buf_n),
        .word          (word),          .word_valid     (word_valid),
        .push_enable   (push_enable),   .pop            (pop),
        .clear_overflow(clear_overflow), .head_word     (head_word),
        .empty         (empty),         .level          (level),
        .overflow      (overflow)
    );

    rx_ctrl u_ctrl (
        .clkGHz_clkbuf (clkGHz_clkbuf), .reset_buf_n   (reset_buf_n),
        .s_axi_awaddr  (s_axi_awaddr),  .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready), .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),   .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),  .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),  .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),  .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready), .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),   .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),  .word          (word),
        .word_valid    (word_valid),    .head_word     (head_word),
        .empty         (empty),         .level         (level),
        .overflow      (overflow),      .tap           (tap),
        .rx_enable     (rx_enable),     .bitslip       (bitslip),
        .push_enable   (push_enable),   .pop           (pop),
        .clear_overflow(clear_overflow)
    );

endmodule

// File: bench/rx_tb.sv
//**********************************************************************
// Testbench for the serial receive path
// Serial word driver, AXI4-Lite tasks, lock, training, FIFO and error tests
//**********************************************************************
`timescale 1ns/1ps

module rx_tb;

    localparam int TIMEOUT = 64;                          // Cycles per handshake wait
    localparam int POLLS   = 150;                         // Register polls before giving up

    logic clkGHz_clkbuf = 1'b0;
    logic reset_buf_n   = 1'b0;
    logic serial_in     = 1'b0;
    rx_pkg::axi_addr_t s_axi_awaddr = '0;
    logic              s_axi_awvalid = 1'b0;
    logic              s_axi_awready;
    rx_pkg::axi_data_t s_axi_wdata = '0;
    logic [3:0]        s_axi_wstrb = 4'hF;
    logic              s_axi_wvalid = 1'b0;
    logic              s_axi_wready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready = 1'b0;
    rx_pkg::axi_addr_t s_axi_araddr = '0;
    logic              s_axi_arvalid = 1'b0;
    logic              s_axi_arready;
    rx_pkg::axi_data_t s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rvalid;
    logic              s_axi_rready = 1'b0;

    logic [15:0]      pat [0:31];                         // Offset, count, data words
    rx_pkg::rx_word_t tx_q [$];                           // Words waiting for the driver
    string            test_name;                          // Test in progress
    int               test_errs, pass_cnt, fail_cnt;

    rx_top DUT (.*);

    always #4 clkGHz_clkbuf = ~clkGHz_clkbuf;             // 8 ns period

    //******************************************************************
    // Reporting helpers
    //******************************************************************
    task automatic report_mismatch(input string check, input int exp, input int act);
        $display("Error in %s, %s: expected %0h actual %0h", test_name, check, exp, act);
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("Problem in %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("Test %s passed", test_name);
            pass_cnt++;
        end else begin
            $display("Test %s failed with %0d errors", test_name, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    //******************************************************************
    // AXI4-Lite master tasks entered and left on a falling edge
    //******************************************************************
    task automatic axi_write(input rx_pkg::axi_addr_t addr, input rx_pkg::axi_data_t data);
        int t;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        t = 0;
        do begin
            @(negedge clkGHz_clkbuf);
            t++;
        end while (!s_axi_awready && t < TIMEOUT);
        if (!s_axi_awready) begin
            report_problem("write address and data were never accepted");
        end else if (s_axi_wready !== 1'b1) begin
            report_mismatch("wready", 1, s_axi_wready);     // Pulses with awready
        end
        @(negedge clkGHz_clkbuf);                          // Handshake edge has passed
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        t = 0;
        while (!s_axi_bvalid && t < TIMEOUT) begin
            @(negedge clkGHz_clkbuf);
            t++;
        end
        if (!s_axi_bvalid) report_problem("write response never arrived");
        if (s_axi_bresp !== rx_pkg::AXI_RESP_OKAY) report_mismatch("bresp", 0, s_axi_bresp);
        s_axi_bready = 1'b1;
        @(negedge clkGHz_clkbuf);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input rx_pkg::axi_addr_t addr, output rx_pkg::axi_data_t data,
                            output logic [1:0] resp);
        int t;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        t = 0;
        do begin
            @(negedge clkGHz_clkbuf);
            t++;
        end while (!s_axi_arready && t < TIMEOUT);
        if (!s_axi_arready) report_problem("read address was never accepted");
        @(negedge clkGHz_clkbuf);
        s_axi_arvalid = 1'b0;
        t = 0;
        while (!s_axi_rvalid && t < TIMEOUT) begin
            @(negedge clkGHz_clkbuf);
            t++;
        end
        if (!s_axi_rvalid) report_problem("read data never arrived");
        data = s_axi_rdata;                                // Stable while rvalid held
        resp = s_axi_rresp;
        s_axi_rready = 1'b1;
        @(negedge clkGHz_clkbuf);
        s_axi_rready = 1'b0;
    endtask

    // Polls STATUS until the given bit is set
    task automatic poll_status(input int bit_idx, input string what,
                               output rx_pkg::axi_data_t status);
        logic [1:0] resp;
        int n;
        n = 0;
        do begin
            axi_read(rx_pkg::ADDR_STATUS, status, resp);
            n++;
        end while (!status[bit_idx] && n < POLLS);
        if (!status[bit_idx]) report_problem({what, " never set in STATUS"});
    endtask

    //******************************************************************
    // Serial driver sending MSB first
    //******************************************************************
    task automatic send_bit(input logic b);
        serial_in = b;
        @(negedge clkGHz_clkbuf);
    endtask

    // Training word whenever nothing is queued
    task automatic drive_serial(input int offset, input int idle);
        rx_pkg::rx_word_t w;
        for (int i = offset - 1; i >= 0; i--) send_bit(rx_pkg::TRAIN_WORD[i]); // Partial word
        repeat (idle) send_bit(1'b0);                      // Random extra bits
        forever begin
            w = (tx_q.size() > 0) ? tx_q.pop_front() : rx_pkg::TRAIN_WORD;
            for (int i = rx_pkg::WORD_W - 1; i >= 0; i--) send_bit(w[i]);
        end
    endtask

    //******************************************************************
    // Test sequence
    //******************************************************************
    initial begin : main_seq
        rx_pkg::axi_data_t d, status;
        logic [1:0] resp;
        int got, n, idle;
        void'($urandom(64));                               // Single seed for the run
        test_errs = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        $readmemh("bench/rx_patterns.hex", pat);
        repeat (16) @(negedge clkGHz_clkbuf);
        reset_buf_n = 1'b1;
        @(negedge clkGHz_clkbuf);

        // Lock
        test_name = "lock";
        axi_read(rx_pkg::ADDR_STATUS, d, resp);
        if (d[0] !== 1'b0) report_mismatch("lock_early", 0, d[0]);
        poll_status(0, "locked", status);
        close_test();

        // Training with the file offset
        test_name = "training";
        axi_write(rx_pkg::ADDR_CTRL, 32'h3);               // Enable, start, tap 0
        idle = $urandom % 3;
        fork
            drive_serial(pat[0], idle);
        join_none
        poll_status(1, "aligned", status);
        if (status[2] !== 1'b0) report_mismatch("train_failed", 0, status[2]);
        axi_read(rx_pkg::ADDR_SLIPS, d, resp);
        if (d < 1 || d > rx_pkg::MAX_SLIPS) begin
            report_problem($sformatf("slip count %0d outside 1 to %0d", d, rx_pkg::MAX_SLIPS));
        end
        close_test();

        // Data capture behind the leading training words
        test_name = "data_capture";
        for (int i = 0; i < pat[1]; i++) tx_q.push_back(pat[2+i][9:0]);
        got = 0;
        n   = 0;
        while (got < pat[1] && n < 4 * POLLS) begin
            axi_read(rx_pkg::ADDR_DATA, d, resp);
            n++;
            if (resp !== rx_pkg::AXI_RESP_OKAY) report_mismatch("data_resp", 0, resp);
            if (d != 0 && !(got == 0 && d == rx_pkg::TRAIN_WORD)) begin
                if (d !== 32'(pat[2+got][9:0])) report_mismatch("data_word", pat[2+got], d);
                got++;
            end
        end
        if (got < pat[1]) report_problem("not all data words were read back");
        axi_write(rx_pkg::ADDR_CTRL, 32'h0);               // Stop filler words
        n = 0;
        do begin
            axi_read(rx_pkg::ADDR_DATA, d, resp);
            n++;
        end while (d != 0 && n < 40);
        axi_read(rx_pkg::ADDR_STATUS, d, resp);
        if (d[3] !== 1'b1) report_mismatch("empty_after_data", 1, d[3]);
        if (d[12:8] !== 5'd0) report_mismatch("level_after_data", 0, d[12:8]);
        close_test();

        // Enable off
        test_name = "enable_off";
        for (int i = 0; i < 4; i++) tx_q.push_back(pat[2+i][9:0]);
        n = 0;
        while (tx_q.size() > 0 && n < 8 * rx_pkg::WORD_W) begin
            @(negedge clkGHz_clkbuf);
            n++;
        end
        if (tx_q.size() > 0) report_problem("serial driver did not send the queued words");
        repeat (2 * rx_pkg::WORD_W) @(negedge clkGHz_clkbuf); // Last word through the delay
        axi_read(rx_pkg::ADDR_STATUS, d, resp);
        if (d[3] !== 1'b1) report_mismatch("empty_disabled", 1, d[3]);
        close_test();

        // Overflow
        test_name = "overflow";
        axi_write(rx_pkg::ADDR_CTRL, 32'h3);               // Retrain after counter restart
        poll_status(1, "aligned", status);
        for (int i = 0; i < 20; i++) tx_q.push_back(pat[2 + (i % pat[1])][9:0]);
        poll_status(4, "overflow", status);
        if (status[12:8] !== 5'd16) report_mismatch("level_full", 16, status[12:8]);
        axi_write(rx_pkg::ADDR_CTRL, 32'h0);
        got = 0;
        for (int i = 0; i < rx_pkg::FIFO_DEPTH; i++) begin
            axi_read(rx_pkg::ADDR_DATA, d, resp);
            if (!(got == 0 && d == rx_pkg::TRAIN_WORD)) begin
                if (d !== 32'(pat[2+got][9:0])) report_mismatch("ovf_word", pat[2+got], d);
                got++;
            end
        end
        if (got < 12) report_problem("too few sent words were kept in the full FIFO");
        axi_write(rx_pkg::ADDR_STATUS, 32'h10);            // Write 1 clears overflow
        axi_read(rx_pkg::ADDR_STATUS, d, resp);
        if (d[4] !== 1'b0) report_mismatch("overflow_clear", 0, d[4]);
        close_test();

        // Error responses
        test_name = "errors";
        axi_read(4'h2, d, resp);
        if (resp !== rx_pkg::AXI_RESP_SLVERR) report_mismatch("unmapped_resp", 2, resp);
        if (d !== 32'd0) report_mismatch("unmapped_data", 0, d);
        axi_read(rx_pkg::ADDR_DATA, d, resp);
        if (resp !== rx_pkg::AXI_RESP_OKAY) report_mismatch("empty_resp", 0, resp);
        if (d !== 32'd0) report_mismatch("empty_data", 0, d);
        close_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: bench/rx_patterns.hex
// Line 1: bit offset, partial training bits sent before the first full word
// Line 2: data word count, then one 10-bit data word per line
0002
0014
0001
02A5
0155
00F3
03C1
007E
019A
02D4
00C8
0333
01F0
0222
038C
004B
0111
02E7
00A9
03FF
016C
005D

// File: flist.f
hw/rx_pkg.sv
hw/rx_bit_delay.sv
hw/rx_deserializer.sv
hw/rx_word_fifo.sv
hw/rx_ctrl.sv
hw/rx_top.sv
bench/rx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --Wno-fatal
TOP       = rx_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
